/* flist.f */
opn_pkg.sv
opn_clk_gen.sv
opn_mmr.sv
opn_timers.sv
opn_pcm_dac.sv
opn_top.sv
tb_clk.sv
opn_assertions.sv
tb_opn.sv

/* opn_assertions.sv */
// Bound into opn_top; assumes clk_div of 1 or more and checks nothing while rst is high
`timescale 1ns/1ns

module opn_assertions (
    input logic clk,
    input logic rst,
    input logic zero,
    input logic flag_a,
    input logic flag_b,
    input logic irq_n,
    input logic snd_sample
);

    int fails = 0;

    // Sample strobe is a single clk pulse
    a_zero_single: assert property (@(posedge clk) disable iff (rst) zero |=> !zero)
        else begin
            $error("zero stayed high for two clocks");
            fails++;
        end

    a_irq_follows_flags: assert property (@(posedge clk) disable iff (rst)
        irq_n == !($past(flag_a) || $past(flag_b)))
        else begin
            $error("irq_n does not match the flags of the previous clock");
            fails++;
        end

    // Output strobe one clk behind zero
    a_sample_after_zero: assert property (@(posedge clk) disable iff (rst)
        snd_sample == $past(zero))
        else begin
            $error("snd_sample does not follow zero by one clock");
            fails++;
        end

endmodule

bind opn_top opn_assertions u_assertions (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .zero       ( zero       ),
    .flag_a     ( flag_a     ),
    .flag_b     ( flag_b     ),
    .irq_n      ( irq_n      ),
    .snd_sample ( snd_sample )
);

/* opn_clk_gen.sv */
// clk_div must be 1 or more; zero comes every clk_div * 24 cen-high clocks
`timescale 1ns/1ns

module opn_clk_gen #(
    parameter int clk_div = 6
) (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic clk_en,
    output logic zero
);

    localparam int CW = (clk_div > 1) ? $clog2(clk_div) : 1;
    localparam int SW = $clog2(opn_pkg::SLOTS_PER_SAMPLE);

    logic [CW-1:0] cen_cnt;
    logic [SW-1:0] slot;

    // Internal clock enable, one pulse per clk_div external enables
    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt <= '0;
            clk_en  <= 1'b0;
        end else begin
            clk_en <= 1'b0;
            if (cen) begin
                if (cen_cnt == CW'(clk_div - 1)) begin
                    cen_cnt <= '0;
                    clk_en  <= 1'b1;
                end else begin
                    cen_cnt <= cen_cnt + 1'b1;
                end
            end
        end
    end

    // Operator slot count, sample strobe on the wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= '0;
            zero <= 1'b0;
        end else begin
            zero <= 1'b0;
            if (clk_en) begin
                if (slot == SW'(opn_pkg::SLOTS_PER_SAMPLE - 1)) begin
                    slot <= '0;
                    zero <= 1'b1;
                end else begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

endmodule

/* opn_mmr.sv */
// Writes only, reads come from the top level; busy is advisory and never blocks a write
`timescale 1ns/1ns

module opn_mmr #(
    parameter int busy_cycles = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               clk_en,
    input  opn_pkg::reg_data_t din,
    input  logic [1:0]         addr,
    input  logic               cs_n,
    input  logic               wr_n,
    output logic               busy,
    output opn_pkg::timer_ctl_t timer_ctl,
    output opn_pkg::dac_ctl_t  dac_ctl
);

    localparam int BW = $clog2(busy_cycles + 1);

    logic write;
    logic wr_addr;
    logic wr_data;

    opn_pkg::reg_addr_t sel_addr;   // Latched register address
    logic               part;       // High for part II

    opn_pkg::timer_a_t  value_a;
    opn_pkg::timer_b_t  value_b;
    opn_pkg::reg_data_t dac_data;
    logic               load_a;
    logic               load_b;
    logic               en_a;
    logic               en_b;
    logic               clr_a;
    logic               clr_b;
    logic               dac_en;
    opn_pkg::pan_t      pan;

    logic [BW-1:0] busy_cnt;

    assign write   = !cs_n && !wr_n;
    assign wr_addr = write && !addr[0];
    assign wr_data = write && addr[0];

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_addr <= '0;
            part     <= 1'b0;
            load_a   <= 1'b0;
            load_b   <= 1'b0;
            en_a     <= 1'b0;
            en_b     <= 1'b0;
            clr_a    <= 1'b0;
            clr_b    <= 1'b0;
            dac_en   <= 1'b0;
            pan      <= 2'b11;
        end else begin
            clr_a <= 1'b0;  // Flag resets last one clk
            clr_b <= 1'b0;
            if (wr_addr) begin
                sel_addr <= din;
                part     <= addr[1];
            end
            if (wr_data && !part) begin
                case (sel_addr)
                    opn_pkg::REG_TIMER_CTL: begin
                        load_a <= din[0];
                        load_b <= din[1];
                        en_a   <= din[2];
                        en_b   <= din[3];
                        clr_a  <= din[4];
                        clr_b  <= din[5];
                    end
                    opn_pkg::REG_DAC_EN: dac_en <= din[7];
                    default: ;
                endcase
            end
            if (wr_data && part && sel_addr == opn_pkg::REG_PAN_CH3) begin
                pan <= din[7:6];    // L, R
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (wr_data && !part) begin
            case (sel_addr)
                opn_pkg::REG_TIMER_A_HI: value_a[9:2] <= din;
                opn_pkg::REG_TIMER_A_LO: value_a[1:0] <= din[1:0];
                opn_pkg::REG_TIMER_B:    value_b      <= din;
                opn_pkg::REG_DAC_DATA:   dac_data     <= din;
                default: ;
            endcase
        end
    end

    // Busy window after each data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_cnt <= '0;
        end else if (wr_data) begin
            busy_cnt <= BW'(busy_cycles);
        end else if (clk_en && busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = busy_cnt != '0;

    assign timer_ctl = '{
        value_a: value_a,
        value_b: value_b,
        load_a:  load_a,
        load_b:  load_b,
        en_a:    en_a,
        en_b:    en_b,
        clr_a:   clr_a,
        clr_b:   clr_b
    };

    assign dac_ctl = '{dac_en: dac_en, dac_data: dac_data, pan: pan};

endmodule

/* opn_pcm_dac.sv */
// Channel 6 DAC only, 8-bit sample without interpolation; outputs change only on the strobe
`timescale 1ns/1ns

module opn_pcm_dac (
    input  logic              clk,
    input  logic              rst,
    input  logic              zero,
    input  opn_pkg::dac_ctl_t dac_ctl,
    output opn_pkg::snd_t     snd_left,
    output opn_pkg::snd_t     snd_right,
    output logic              snd_sample
);

    opn_pkg::snd_t sample;

    // Offset binary to two's complement, scaled to the top byte
    assign sample = {~dac_ctl.dac_data[7], dac_ctl.dac_data[6:0], 8'd0};

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_left   <= '0;
            snd_right  <= '0;
            snd_sample <= 1'b0;
        end else begin
            snd_sample <= zero;
            if (zero) begin
                snd_left  <= (dac_ctl.dac_en && dac_ctl.pan[1]) ? sample : '0;
                snd_right <= (dac_ctl.dac_en && dac_ctl.pan[0]) ? sample : '0;
            end
        end
    end

endmodule

/* opn_pkg.sv */
// Control subset of an OPN chip only; no FM, LFO, SSG or ADPCM fields, timer A is 10 bits
package opn_pkg;

    typedef logic [7:0]         reg_addr_t;
    typedef logic [7:0]         reg_data_t;
    typedef logic [9:0]         timer_a_t;
    typedef logic [7:0]         timer_b_t;
    typedef logic signed [15:0] snd_t;
    typedef logic [1:0]         pan_t;      // Bit 1 left, bit 0 right

    // Timer settings from the register file
    typedef struct packed {
        timer_a_t value_a;
        timer_b_t value_b;
        logic     load_a;   // Level, counter runs while high
        logic     load_b;
        logic     en_a;     // Flag enables
        logic     en_b;
        logic     clr_a;    // One clk pulse
        logic     clr_b;
    } timer_ctl_t;

    // Channel 6 DAC settings
    typedef struct packed {
        logic      dac_en;
        reg_data_t dac_data;    // Offset binary
        pan_t      pan;
    } dac_ctl_t;

    // Part I addresses unless noted
    localparam reg_addr_t REG_TIMER_A_HI = 8'h24;
    localparam reg_addr_t REG_TIMER_A_LO = 8'h25;
    localparam reg_addr_t REG_TIMER_B    = 8'h26;
    localparam reg_addr_t REG_TIMER_CTL  = 8'h27;
    localparam reg_addr_t REG_DAC_DATA   = 8'h2A;
    localparam reg_addr_t REG_DAC_EN     = 8'h2B;
    localparam reg_addr_t REG_PAN_CH3    = 8'hB6;   // Part II, i.e. channel 6

    localparam int SLOTS_PER_SAMPLE = 24;   // clk_en ticks per sample
    localparam int TIMER_B_PRESCALE = 16;   // Samples per timer B step

endpackage

/* opn_timers.sv */
// Timers step on the sample strobe only; timer B prescaler runs freely, so its period varies by one phase
`timescale 1ns/1ns

module opn_timers (
    input  logic                clk,
    input  logic                rst,
    input  logic                zero,
    input  opn_pkg::timer_ctl_t timer_ctl,
    output logic                flag_a,
    output logic                flag_b,
    output logic                irq_n
);

    localparam int PW = $clog2(opn_pkg::TIMER_B_PRESCALE);

    opn_pkg::timer_a_t cnt_a;
    opn_pkg::timer_b_t cnt_b;
    logic [PW-1:0]     pre_b;
    logic              load_a_d;
    logic              load_b_d;
    logic              tick_b;
    logic              step_a;
    logic              step_b;
    logic              ovf_a;
    logic              ovf_b;

    // Load edge has priority over a step
    assign step_a = timer_ctl.load_a && load_a_d && zero;
    assign ovf_a  = step_a && (&cnt_a);

    assign tick_b = zero && pre_b == PW'(opn_pkg::TIMER_B_PRESCALE - 1);
    assign step_b = timer_ctl.load_b && load_b_d && tick_b;
    assign ovf_b  = step_b && (&cnt_b);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_a_d <= 1'b0;
            cnt_a    <= '0;
        end else begin
            load_a_d <= timer_ctl.load_a;
            if (timer_ctl.load_a && !load_a_d) begin
                cnt_a <= timer_ctl.value_a;
            end else if (step_a) begin
                cnt_a <= ovf_a ? timer_ctl.value_a : cnt_a + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_b_d <= 1'b0;
            cnt_b    <= '0;
            pre_b    <= '0;
        end else begin
            load_b_d <= timer_ctl.load_b;
            if (zero) begin
                pre_b <= pre_b + 1'b1;  // Wraps at the prescale count
            end
            if (timer_ctl.load_b && !load_b_d) begin
                cnt_b <= timer_ctl.value_b;
            end else if (step_b) begin
                cnt_b <= ovf_b ? timer_ctl.value_b : cnt_b + 1'b1;
            end
        end
    end

    // Sticky flags, cleared only by the reset bits
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
            irq_n  <= 1'b1;
        end else begin
            if (timer_ctl.clr_a) begin
                flag_a <= 1'b0;
            end else if (ovf_a && timer_ctl.en_a) begin
                flag_a <= 1'b1;
            end
            if (timer_ctl.clr_b) begin
                flag_b <= 1'b0;
            end else if (ovf_b && timer_ctl.en_b) begin
                flag_b <= 1'b1;
            end
            irq_n <= !(flag_a || flag_b);   // Lags the flags by one clk
        end
    end

endmodule

/* opn_top.sv */
// Sound outputs carry the channel 6 DAC alone; dout is the status byte, zero while cs_n is high
`timescale 1ns/1ns

module opn_top #(
    parameter int clk_div     = 6,
    parameter int busy_cycles = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               cs_n,
    input  logic               wr_n,
    input  opn_pkg::reg_data_t din,
    input  logic [1:0]         addr,
    output opn_pkg::reg_data_t dout,
    output logic               irq_n,
    output opn_pkg::snd_t      snd_left,
    output opn_pkg::snd_t      snd_right,
    output logic               snd_sample
);

    logic                clk_en;
    logic                zero;      // Sample strobe
    logic                busy;
    logic                flag_a;
    logic                flag_b;
    opn_pkg::timer_ctl_t timer_ctl;
    opn_pkg::dac_ctl_t   dac_ctl;

    opn_clk_gen #(.clk_div(clk_div)) u_clk_gen (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .cen    ( cen    ),
        .clk_en ( clk_en ),
        .zero   ( zero   )
    );

    opn_mmr #(.busy_cycles(busy_cycles)) u_mmr (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .clk_en    ( clk_en    ),
        .din       ( din       ),
        .addr      ( addr      ),
        .cs_n      ( cs_n      ),
        .wr_n      ( wr_n      ),
        .busy      ( busy      ),
        .timer_ctl ( timer_ctl ),
        .dac_ctl   ( dac_ctl   )
    );

    opn_timers u_timers (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .zero      ( zero      ),
        .timer_ctl ( timer_ctl ),
        .flag_a    ( flag_a    ),
        .flag_b    ( flag_b    ),
        .irq_n     ( irq_n     )
    );

    opn_pcm_dac u_pcm_dac (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .zero       ( zero       ),
        .dac_ctl    ( dac_ctl    ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    // Status byte
    assign dout = cs_n ? '0 : {busy, 5'd0, flag_b, flag_a};

endmodule

/* opn_trace.txt */
# Commands, hex values: test <name> | wa <part> <reg> | wd <data> | st <status> | idle
# irq <max samples> and hold <samples> in decimal | snd <left> <right> of the next sample
test reset
st 00
hold 1
snd 0000 0000
test busy
wa 0 2a
wd 80
st 80
idle
st 00
test timer_a
wa 0 24
wd ff
wa 0 25
wd 00
wa 0 27
wd 05
irq 5
idle
st 01
wd 10
idle
st 00
hold 1
test timer_b
wa 0 26
wd ff
wa 0 27
wd 0a
irq 33
idle
st 02
wd 20
idle
st 00
wd 01
hold 20
wd 00
test dac
wa 0 2b
wd 80
wa 1 b6
wd 80
wa 0 2a
wd c0
snd 4000 0000
wa 1 b6
wd c0
wa 0 2a
wd 20
snd a000 a000
wa 0 2b
wd 00
snd 0000 0000

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, pass or fail taken from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_opn -f flist.f -o sim_opn
./obj_dir/sim_opn | tee sim.log

if grep -q "^All checks passed$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tb_clk.sv */
// Free-running clock that starts low; the period must be an even number of ns
`timescale 1ns/1ns

module tb_clk #(
    parameter int period_ns = 20
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period_ns / 2) clk = ~clk;

endmodule

/* tb_opn.sv */
// Replays opn_trace.txt from the project root with cen held high; one sample is 144 clk
`timescale 1ns/1ns

module tb_opn;

    localparam int CLK_DIV     = 6;
    localparam int BUSY_CYCLES = 32;
    localparam int BUSY_BOUND  = BUSY_CYCLES * CLK_DIV + 10;     // clk
    localparam int SAMPLE_CLK  = CLK_DIV * opn_pkg::SLOTS_PER_SAMPLE;
    localparam int PERIOD_NS   = 20;

    logic               clk;
    logic               rst;
    logic               cen;
    logic               cs_n;
    logic               wr_n;
    opn_pkg::reg_data_t din;
    logic [1:0]         addr;
    opn_pkg::reg_data_t dout;
    logic               irq_n;
    opn_pkg::snd_t      snd_left;
    opn_pkg::snd_t      snd_right;
    logic               snd_sample;

    // Parsed trace
    string cmd_q[$];
    string text_q[$];
    int    arg1_q[$];
    int    arg2_q[$];

    int    fd;
    int    r;
    int    a1;
    int    a2;
    string word;
    string name;
    string line;
    string cur_name = "";
    int    watch_ns = 0;
    bit    parsed = 1'b0;
    int    checks = 0;
    int    errors = 0;
    int    test_errs = 0;
    int    passed = 0;
    int    failed = 0;

    tb_clk #(.period_ns(PERIOD_NS)) u_clk (.clk(clk));

    opn_top #(.clk_div(CLK_DIV), .busy_cycles(BUSY_CYCLES)) DUT (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen        ( cen        ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .din        ( din        ),
        .addr       ( addr       ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    task automatic note_error();
        errors++;
        test_errs++;
    endtask

    task automatic finish_test();
        if (cur_name != "") begin
            if (test_errs == 0) begin
                passed++;
                $display("Test %s passed", cur_name);
            end else begin
                failed++;
                $display("Test %s failed with %0d errors", cur_name, test_errs);
            end
        end
    endtask

    // Polls the busy bit through status reads
    task automatic wait_ready();
        int waited;
        waited = 0;
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b1;
        @(negedge clk);
        while (dout[7] && waited < BUSY_BOUND) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        if (dout[7]) begin
            $display("Timeout at %0t ns: busy still set after %0d clocks", $time, BUSY_BOUND);
            note_error();
        end
        @(posedge clk);
        cs_n <= 1'b1;
    endtask

    task automatic bus_write(input logic [1:0] a, input int d);
        wait_ready();
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        addr <= a;
        din  <= opn_pkg::reg_data_t'(d);
        @(posedge clk);     // Write edge
        cs_n <= 1'b1;
        wr_n <= 1'b1;
    endtask

    task automatic check_status(input int expected);
        opn_pkg::reg_data_t got;
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b1;
        @(negedge clk);
        got = dout;
        @(posedge clk);
        cs_n <= 1'b1;
        checks++;
        if (got !== opn_pkg::reg_data_t'(expected)) begin
            $display("FAILED at %0t ns: status 0x%02h, expected 0x%02h", $time, got,
                     opn_pkg::reg_data_t'(expected));
            note_error();
        end
    endtask

    task automatic wait_irq(input int max_samples);
        int seen;
        seen = 0;
        while (irq_n && seen <= max_samples) begin
            @(negedge clk);
            if (snd_sample) seen++;
        end
        checks++;
        if (irq_n) begin
            $display("Timeout at %0t ns: no interrupt within %0d samples", $time, max_samples);
            note_error();
        end
    endtask

    task automatic hold_irq(input int samples);
        int seen;
        bit dropped;
        seen = 0;
        dropped = 1'b0;
        while (seen < samples && !dropped) begin
            @(negedge clk);
            if (!irq_n) dropped = 1'b1;
            if (snd_sample) seen++;
        end
        checks++;
        if (dropped) begin
            $display("FAILED at %0t ns: irq_n low, expected high", $time);
            note_error();
        end
    endtask

    // Skips a strobe that could still carry the old register values
    task automatic check_sound(input int left, input int right);
        int waited;
        waited = 0;
        @(posedge clk);
        @(negedge clk);
        while (!snd_sample && waited < SAMPLE_CLK + 10) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        if (!snd_sample) begin
            $display("Timeout at %0t ns: no sample strobe", $time);
            note_error();
        end else if (snd_left !== opn_pkg::snd_t'(left)
                     || snd_right !== opn_pkg::snd_t'(right)) begin
            $display("FAILED at %0t ns: sound %0d/%0d, expected %0d/%0d", $time,
                     snd_left, snd_right, opn_pkg::snd_t'(left), opn_pkg::snd_t'(right));
            note_error();
        end
    endtask

    // Watchdog armed once the trace bounds are known
    initial begin
        wait (parsed);
        #(watch_ns);
        $display("Watchdog: run did not finish within %0d ns", watch_ns);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst  = 1'b1;
        cen  = 1'b1;
        cs_n = 1'b1;
        wr_n = 1'b1;
        din  = '0;
        addr = '0;
        a1   = 0;
        a2   = 0;
        fd = $fopen("opn_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file opn_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                name = "";
                if ($fscanf(fd, "%s", word) == 1) begin
                    if (word.substr(0, 0) == "#") begin
                        r = $fgets(line, fd);   // Comment line
                    end else begin
                        r = 0;  // Count of missing arguments
                        if (word == "test") r = $fscanf(fd, "%s", name) - 1;
                        if (word == "irq" || word == "hold") r = $fscanf(fd, "%d", a1) - 1;
                        if (word == "wd" || word == "st") r = $fscanf(fd, "%h", a1) - 1;
                        if (word == "wa" || word == "snd") r = $fscanf(fd, "%h %h", a1, a2) - 2;
                        if (r != 0) begin
                            $display("Trace command %s is missing its arguments", word);
                            errors++;
                        end
                        if (word == "irq" || word == "hold") watch_ns += a1 * SAMPLE_CLK;
                        if (word == "snd") watch_ns += 2 * SAMPLE_CLK;
                        watch_ns += BUSY_BOUND + 8;
                        cmd_q.push_back(word);
                        text_q.push_back(name);
                        arg1_q.push_back(a1);
                        arg2_q.push_back(a2);
                    end
                end
            end
            $fclose(fd);
        end
        watch_ns = (watch_ns + 2 * SAMPLE_CLK) * PERIOD_NS;   // Margin of two samples
        parsed = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < cmd_q.size(); i++) begin
            case (cmd_q[i])
                "test": begin
                    finish_test();
                    cur_name = text_q[i];
                    test_errs = 0;
                end
                "wa":    bus_write((arg1_q[i] != 0) ? 2'b10 : 2'b00, arg2_q[i]);
                "wd":    bus_write(2'b01, arg1_q[i]);
                "st":    check_status(arg1_q[i]);
                "idle":  wait_ready();
                "irq":   wait_irq(arg1_q[i]);
                "hold":  hold_irq(arg1_q[i]);
                "snd":   check_sound(arg1_q[i], arg2_q[i]);
                default: begin
                    $display("Unknown trace command %s", cmd_q[i]);
                    note_error();
                end
            endcase
        end
        finish_test();
        errors += DUT.u_assertions.fails;   // Bound checker failures
        $display("%0d tests: %0d passed, %0d failed; %0d checks, %0d errors",
                 passed + failed, passed, failed, checks, errors);
        if (errors == 0 && failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
